/* design/csa_pkg.sv */
`default_nettype none

package csa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int unsigned WORD_W = 32; // host bus word.
	localparam int unsigned CW48_W = 48; // six cw bytes without the checksums.
	localparam int unsigned CW64_W = 64; // full cw with checksum bytes.

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [CW48_W-1:0] cw48_t;
	typedef logic [CW64_W-1:0] cw64_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// mixing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// added modulo 2**64 in every round.
	localparam cw64_t MIX_ADD = 64'h9e37_79b9_7f4a_7c15;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// job and result records
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one search job as written by the host.
	typedef struct packed {
		word_t block;       // job id echoed back.
		cw48_t cw_base;     // base of the candidate range.
		word_t times;       // candidate count.
		word_t times_start; // offset of the first candidate.
	} csa_job_t;

	// job fields plus the folded digest.
	typedef struct packed {
		word_t block;
		cw48_t cw_base;
		word_t times;
		word_t times_start;
		cw64_t digest; // xor over all candidate digests.
	} csa_result_t;

endpackage

`default_nettype wire

/* design/job_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module job_fifo #(
	parameter int unsigned DEPTH = 4,
	parameter type payload_t = logic [31:0]
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic wr_valid_i,
	output logic wr_ready_o,
	input wire payload_t wr_data_i,

	output logic rd_valid_o,
	input wire logic rd_ready_i,
	output payload_t rd_data_o
);

	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic wr_fire;
	logic rd_fire;

	// wraps at DEPTH, so any depth works.
	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign wr_ready_o = (count_q != CNT_W'(DEPTH)); // low while full.
	assign rd_valid_o = (count_q != '0);            // low while empty.
	assign rd_data_o = mem[rd_ptr_q];

	assign wr_fire = wr_valid_i & wr_ready_o;
	assign rd_fire = rd_valid_o & rd_ready_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointers and occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (rd_fire) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({wr_fire, rd_fire})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q; // none, or one in and one out.
			endcase
		end
	end

	// storage.
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[wr_ptr_q] <= wr_data_i;
		end
	end

endmodule

`default_nettype wire

/* design/csa_cw_mix_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module csa_cw_mix_pipe
	import csa_pkg::*;
#(
	parameter int unsigned MIX_ROUNDS = 8
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic cand_valid_i,
	input wire cw48_t cand_i,
	input wire logic last_i,

	output logic dig_valid_o,
	output cw64_t dig_o,
	output logic last_o
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checksum expansion and one mixing round
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// cw bytes 0..5 land at 0,1,2,4,5,6; 3 and 7 are the byte sums.
	function automatic cw64_t cw_expand(cw48_t cand);
		logic [7:0] sum_lo;
		logic [7:0] sum_hi;
		sum_lo = cand[7:0] + cand[15:8] + cand[23:16];
		sum_hi = cand[31:24] + cand[39:32] + cand[47:40];
		return {sum_hi, cand[47:24], sum_lo, cand[23:0]};
	endfunction

	function automatic cw64_t mix_round(cw64_t x);
		cw64_t rot;
		cw64_t fold;
		rot = {x[55:0], x[63:56]}; // rotate left by one byte.
		fold = rot ^ (rot >> 3);
		return fold + MIX_ADD;
	endfunction

	cw64_t cw_exp;
	cw64_t stage_q [MIX_ROUNDS];
	logic [MIX_ROUNDS-1:0] valid_q;
	logic [MIX_ROUNDS-1:0] last_q;

	assign cw_exp = cw_expand(cand_i);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// round stages
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// tags travel in lockstep with the data.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			last_q <= '0;
		end else begin
			valid_q[0] <= cand_valid_i;
			last_q[0] <= cand_valid_i & last_i;
			for (int i = 1; i < MIX_ROUNDS; i++) begin
				valid_q[i] <= valid_q[i-1];
				last_q[i] <= last_q[i-1];
			end
		end
	end

	// one round per register, never stalls.
	always_ff @(posedge clk) begin
		stage_q[0] <= mix_round(cw_exp);
		for (int i = 1; i < MIX_ROUNDS; i++) begin
			stage_q[i] <= mix_round(stage_q[i-1]);
		end
	end

	assign dig_valid_o = valid_q[MIX_ROUNDS-1];
	assign dig_o = stage_q[MIX_ROUNDS-1];
	assign last_o = last_q[MIX_ROUNDS-1];

endmodule

`default_nettype wire

/* design/csa_calc_logic.sv */
`timescale 1ns/100ps
`default_nettype none

module csa_calc_logic
	import csa_pkg::*;
#(
	parameter int unsigned MIX_ROUNDS = 8
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic job_valid_i,
	output logic job_ready_o,
	input wire csa_job_t job_i,

	output logic res_valid_o,
	input wire logic res_ready_i,
	output csa_result_t res_o
);

	typedef enum logic [1:0] {
		ST_IDLE,  // waiting for a job.
		ST_RUN,   // issuing candidates.
		ST_DRAIN, // waiting for the last digest.
		ST_DONE   // result held until taken.
	} state_t;

	state_t state_q;
	word_t remain_q;
	csa_job_t job_q;
	cw48_t cand_q;
	cw64_t acc_q;

	logic job_fire;
	logic res_fire;
	logic cand_valid;
	logic cand_last;
	logic dig_valid;
	cw64_t dig;
	logic dig_last;

	assign job_ready_o = (state_q == ST_IDLE);
	assign res_valid_o = (state_q == ST_DONE);
	assign job_fire = job_valid_i & job_ready_o;
	assign res_fire = res_valid_o & res_ready_i;

	assign cand_valid = (state_q == ST_RUN);
	assign cand_last = (remain_q == word_t'(1)); // only looked at while running.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			remain_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (job_fire) begin
						remain_q <= job_i.times;
						// zero-length job never enters the pipe.
						state_q <= (job_i.times == '0) ? ST_DONE : ST_RUN;
					end
				end
				ST_RUN: begin
					remain_q <= remain_q - 1'b1;
					if (cand_last) begin
						state_q <= ST_DRAIN;
					end
				end
				ST_DRAIN: begin
					if (dig_valid && dig_last) begin
						state_q <= ST_DONE;
					end
				end
				ST_DONE: begin
					if (res_fire) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// candidate counter and digest accumulator
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (job_fire) begin
			job_q <= job_i;
			cand_q <= job_i.cw_base + cw48_t'(job_i.times_start); // wraps mod 2**48.
			acc_q <= '0;
		end else begin
			if (cand_valid) begin
				cand_q <= cand_q + 1'b1;
			end
			if (dig_valid) begin
				acc_q <= acc_q ^ dig;
			end
		end
	end

	csa_cw_mix_pipe #(
		.MIX_ROUNDS(MIX_ROUNDS)
	) i_mix_pipe (
		.clk(clk),
		.rst_n(rst_n),
		.cand_valid_i(cand_valid),
		.cand_i(cand_q),
		.last_i(cand_last),
		.dig_valid_o(dig_valid),
		.dig_o(dig),
		.last_o(dig_last)
	);

	// job fields go back unchanged.
	always_comb begin
		res_o.block = job_q.block;
		res_o.cw_base = job_q.cw_base;
		res_o.times = job_q.times;
		res_o.times_start = job_q.times_start;
		res_o.digest = acc_q;
	end

endmodule

`default_nettype wire

/* design/csa_calc_logic_wrap.sv */
`timescale 1ns/100ps
`default_nettype none

module csa_calc_logic_wrap
	import csa_pkg::*;
#(
	parameter int unsigned MIX_ROUNDS = 8,
	parameter int unsigned IN_DEPTH = 4,
	parameter int unsigned OUT_DEPTH = 4
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic in_valid_i,
	output logic in_ready_o,
	input wire csa_job_t in_job_i,

	output logic out_valid_o,
	input wire logic out_ready_i,
	output csa_result_t out_result_o
);

	// input queue to engine.
	logic job_valid;
	logic job_ready;
	csa_job_t job;

	// engine to output queue.
	logic res_valid;
	logic res_ready;
	csa_result_t res;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// job queue, engine, result queue
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	job_fifo #(
		.DEPTH(IN_DEPTH),
		.payload_t(csa_job_t)
	) i_in_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid_i(in_valid_i),
		.wr_ready_o(in_ready_o),
		.wr_data_i(in_job_i),
		.rd_valid_o(job_valid),
		.rd_ready_i(job_ready),
		.rd_data_o(job)
	);

	csa_calc_logic #(
		.MIX_ROUNDS(MIX_ROUNDS)
	) i_calc (
		.clk(clk),
		.rst_n(rst_n),
		.job_valid_i(job_valid),
		.job_ready_o(job_ready),
		.job_i(job),
		.res_valid_o(res_valid),
		.res_ready_i(res_ready),
		.res_o(res)
	);

	job_fifo #(
		.DEPTH(OUT_DEPTH),
		.payload_t(csa_result_t)
	) i_out_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid_i(res_valid),
		.wr_ready_o(res_ready),
		.wr_data_i(res),
		.rd_valid_o(out_valid_o),
		.rd_ready_i(out_ready_i),
		.rd_data_o(out_result_o)
	);

endmodule

`default_nettype wire

/* include/csa_ref_model.svh */
`ifndef CSA_REF_MODEL_SVH
`define CSA_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioural model of the engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// insert the two checksum bytes.
function automatic cw64_t expand_cw(cw48_t cand);
	logic [7:0] b [8];
	cw64_t cw;
	b[0] = cand[7:0];
	b[1] = cand[15:8];
	b[2] = cand[23:16];
	b[4] = cand[31:24];
	b[5] = cand[39:32];
	b[6] = cand[47:40];
	b[3] = b[0] + b[1] + b[2];
	b[7] = b[4] + b[5] + b[6];
	for (int i = 0; i < 8; i++) begin
		cw[8*i +: 8] = b[i];
	end
	return cw;
endfunction

function automatic cw64_t mix_cw(cw64_t cw, int rounds);
	cw64_t x;
	x = cw;
	for (int r = 0; r < rounds; r++) begin
		x = {x[55:0], x[63:56]};
		x = x ^ (x >> 3);
		x = x + MIX_ADD;
	end
	return x;
endfunction

// zero when times is zero.
function automatic cw64_t job_digest(csa_job_t job, int rounds);
	cw64_t acc;
	cw48_t cand;
	acc = '0;
	cand = job.cw_base + cw48_t'(job.times_start);
	for (longint unsigned k = 0; k < job.times; k++) begin
		acc = acc ^ mix_cw(expand_cw(cand), rounds);
		cand = cand + 1'b1;
	end
	return acc;
endfunction

function automatic csa_result_t expected_result(csa_job_t job, int rounds);
	csa_result_t res;
	res.block = job.block;
	res.cw_base = job.cw_base;
	res.times = job.times;
	res.times_start = job.times_start;
	res.digest = job_digest(job, rounds);
	return res;
endfunction

`endif

/* testbench/tb_csa_calc_logic_wrap.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_csa_calc_logic_wrap
	import csa_pkg::*;
();

	localparam int unsigned MIX_ROUNDS = 8;
	localparam int unsigned IN_DEPTH = 4;
	localparam int unsigned OUT_DEPTH = 4;
	localparam int unsigned RESET_CYCLES = 10;
	localparam int unsigned STALL_CYCLES = 250; // output blocked this long.
	localparam int unsigned JOB_MARGIN = 2 * MIX_ROUNDS + 16;
	localparam int N_GROUPS = 6;

	`include "csa_ref_model.svh"

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	csa_job_t in_job;
	logic out_valid;
	logic out_ready;
	csa_result_t out_result;

	integer seed;
	int errors;
	int n_checked;
	int ready_mode; // 0 is always ready, 1 blocked and 2 random.
	longint unsigned total_cands;
	int grp_len [N_GROUPS];
	csa_job_t jobs_q [$];
	csa_result_t exp_q [$]; // expected results in send order.
	csa_result_t exp_res;

	csa_calc_logic_wrap #(
		.MIX_ROUNDS(MIX_ROUNDS),
		.IN_DEPTH(IN_DEPTH),
		.OUT_DEPTH(OUT_DEPTH)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid_i(in_valid),
		.in_ready_o(in_ready),
		.in_job_i(in_job),
		.out_valid_o(out_valid),
		.out_ready_i(out_ready),
		.out_result_o(out_result)
	);

	always #2 clk = ~clk; // 4 ns period.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// job list
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, want);
		end
	endtask

	function automatic cw48_t rand_cw48();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi[15:0], lo};
	endfunction

	task automatic add_job(input cw48_t base, input word_t times, input word_t start);
		csa_job_t job;
		job.block = word_t'(jobs_q.size() + 32'h100);
		job.cw_base = base;
		job.times = times;
		job.times_start = start;
		jobs_q.push_back(job);
		total_cands += times;
	endtask

	task automatic add_random_jobs(input int n, input int max_times);
		word_t times;
		for (int i = 0; i < n; i++) begin
			times = word_t'(1 + ($unsigned($random(seed)) % max_times));
			add_job(rand_cw48(), times, $random(seed));
		end
	endtask

	task automatic build_jobs();
		add_job(rand_cw48(), 1, 0); // single candidate.
		grp_len[0] = 1;
		add_job(rand_cw48(), 0, $random(seed)); // empty range.
		grp_len[1] = 1;
		add_job(48'hffff_ffff_fff0, 20, 8); // ranges that wrap past 2**48.
		add_job(48'hffff_ffff_ffff, 5, 32'hffff_fffe);
		add_job(48'hffff_fff0_0000, 30, 32'h000f_fff0);
		grp_len[2] = 3;
		add_random_jobs(20, 40);
		grp_len[3] = 20;
		add_random_jobs(12, 6); // more than the queues and engine can hold.
		grp_len[4] = 12;
		add_random_jobs(15, 40);
		grp_len[5] = 15;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// drivers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// starts 1 ns after an edge and returns 1 ns after the transfer edge.
	task automatic send_job(input csa_job_t job);
		in_job = job;
		in_valid = 1'b1;
		do begin
			@(posedge clk);
		end while (!in_ready);
		exp_q.push_back(expected_result(job, MIX_ROUNDS));
		#1;
		in_valid = 1'b0;
	endtask

	task automatic send_group(input int first, input int n);
		for (int i = 0; i < n; i++) begin
			send_job(jobs_q[first + i]);
		end
	endtask

	task automatic blocked_run(input int first, input int n);
		bit saw_full;
		saw_full = 1'b0;
		ready_mode = 1;
		fork
			send_group(first, n);
			begin
				repeat (STALL_CYCLES) begin
					@(posedge clk);
					if (!in_ready) begin
						saw_full = 1'b1;
					end
				end
				if (!saw_full) begin
					errors++;
					$display("input queue never filled while the output was blocked");
				end
				ready_mode = 0; // release the output.
			end
		join
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic watchdog(input longint unsigned cycles);
		repeat (cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles", cycles);
		$display("errors: %0d, results checked: %0d of %0d", errors, n_checked,
			jobs_q.size());
		$display("CHECKS FAILED");
		$finish;
	endtask

	always @(posedge clk) begin
		logic [31:0] r;
		#1;
		r = $random(seed);
		case (ready_mode)
			0: out_ready = 1'b1;
			1: out_ready = 1'b0;
			default: out_ready = r[4];
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scoreboard
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("result for block %h at %0t ns with no job outstanding",
					out_result.block, $time);
			end else begin
				exp_res = exp_q.pop_front();
				check_value("block", out_result.block, exp_res.block);
				check_value("cw_base", out_result.cw_base, exp_res.cw_base);
				check_value("times", out_result.times, exp_res.times);
				check_value("times_start", out_result.times_start, exp_res.times_start);
				check_value("digest", out_result.digest, exp_res.digest);
				n_checked++;
			end
		end
	end

	initial begin
		longint unsigned limit;
		int first;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_job = '0;
		out_ready = 1'b0;
		seed = 32'h5d9c_f9be;
		errors = 0;
		n_checked = 0;
		ready_mode = 0;
		total_cands = 0;
		build_jobs();
		limit = RESET_CYCLES + total_cands + jobs_q.size() * JOB_MARGIN + STALL_CYCLES;
		fork
			watchdog(limit);
		join_none
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value("out_valid after reset", out_valid, 1'b0);
		first = 0;
		for (int g = 0; g < N_GROUPS; g++) begin
			if (g == 4) begin
				blocked_run(first, grp_len[g]);
			end else begin
				ready_mode = (g == 5) ? 2 : 0;
				send_group(first, grp_len[g]);
			end
			wait_drain();
			first += grp_len[g];
		end
		if (n_checked != jobs_q.size()) begin
			errors++;
			$display("only %0d of %0d results arrived", n_checked, jobs_q.size());
		end
		$display("errors: %0d, results checked: %0d of %0d", errors, n_checked, jobs_q.size());
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
design/csa_pkg.sv
design/job_fifo.sv
design/csa_cw_mix_pipe.sv
design/csa_calc_logic.sv
design/csa_calc_logic_wrap.sv
testbench/tb_csa_calc_logic_wrap.sv

/* Bender.yml */
package:
  name: csa_calc_logic

sources:
  - files:
      - design/csa_pkg.sv
      - design/job_fifo.sv
      - design/csa_cw_mix_pipe.sv
      - design/csa_calc_logic.sv
      - design/csa_calc_logic_wrap.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_csa_calc_logic_wrap.sv
